// File: rot_cfg_pkg.sv
// ----------------------------------------------------------
// Sizes shared by the weight rotator blocks
// Stream widths, bank depth and the loop field widths that
// make up the packet header
// ----------------------------------------------------------
`default_nettype none

package rot_cfg_pkg;

  // Stream and bank geometry
  localparam int S_WIDTH    = 32;   // Input beat, one half row
  localparam int ROW_WIDTH  = 64;   // Bank row and output beat
  localparam int BANK_DEPTH = 256;  // Rows per bank
  localparam int ADDR_BITS  = 8;

  // Loop field widths in the header
  localparam int KW2_BITS = 2, CIN_BITS = 4, COLS_BITS = 4, BLK_BITS = 3, XN_BITS = 3;

  // Kernel width counter runs up to 2*kw2
  localparam int KW_BITS = KW2_BITS + 1;

  // Unused top bits of the header word
  localparam int HDR_PAD = S_WIDTH
                         - (ADDR_BITS + XN_BITS + BLK_BITS + COLS_BITS + CIN_BITS + KW2_BITS);

endpackage

`default_nettype wire

// File: rot_hdr_pkg.sv
// ----------------------------------------------------------
// Header and sideband types of the weight rotator
// The first beat of a packet is read as hdr_cfg_t and
// forwarded raw on the config output beat
// ----------------------------------------------------------
`default_nettype none

package rot_hdr_pkg;
  import rot_cfg_pkg::*;

  // Loop geometry, each _1 field is its count minus one
  typedef struct packed {
    logic [HDR_PAD-1:0]   pad;
    logic [ADDR_BITS-1:0] addr_max;  // Last row index in the packet
    logic [XN_BITS-1:0]   xn_1;
    logic [BLK_BITS-1:0]  blocks_1;
    logic [COLS_BITS-1:0] cols_1;
    logic [CIN_BITS-1:0]  cin_1;
    logic [KW2_BITS-1:0]  kw2;       // Kernel width is 2*kw2+1
  } hdr_cfg_t;

  // Same header beat, seen as fields or as the raw word
  typedef union packed {
    hdr_cfg_t           cfg;
    logic [S_WIDTH-1:0] raw;
  } hdr_u;

  // Sideband flags on every output beat
  typedef struct packed {
    logic                is_config;
    logic [KW2_BITS-1:0] kw2;
    logic                is_w_first;
    logic                is_cin_last;
    logic                is_w_last;
  } rot_user_t;

endpackage

`default_nettype wire

// File: bank_if.sv
// ----------------------------------------------------------
// Link between the controller and the ping-pong bank store
// The row packer drives wr_data and wr_last from the top
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bank_if
  import rot_cfg_pkg::*;
();

  logic                 wr_en;
  logic [ROW_WIDTH-1:0] wr_data;
  logic                 wr_last;   // Final row of the packet
  logic                 rd_en;
  logic [ROW_WIDTH-1:0] rd_data;
  logic                 rd_valid;  // One cycle after rd_en
  logic                 sel_wr;
  logic                 sel_rd;
  logic                 clr_wr;    // Rewind write pointer of sel_wr bank
  logic [ADDR_BITS-1:0] addr_max;  // Read wrap point

  modport ctrl (
    output wr_en, rd_en, sel_wr, sel_rd, clr_wr, addr_max,
    input  wr_last
  );

  modport bank (
    input  wr_en, wr_data, rd_en, sel_wr, sel_rd, clr_wr, addr_max,
    output rd_data, rd_valid
  );

endinterface

`default_nettype wire

// File: row_packer.sv
// ----------------------------------------------------------
// Packs two 32-bit input beats into one 64-bit bank row
// Low half arrives first, the row carries the last mark of
// its second beat and is shown for a single cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module row_packer
  import rot_cfg_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  logic [S_WIDTH-1:0]   i_data,
  input  logic                 i_last,
  input  logic                 i_en,
  output logic                 o_row_valid,
  output logic [ROW_WIDTH-1:0] o_row,
  output logic                 o_row_last
);

  logic [S_WIDTH-1:0] lo_q;
  logic               half_q;  // Low half held
  logic               take;

  // Hold off while a row is out or the write side is closed
  assign o_ready = i_en && !o_row_valid;
  assign take    = i_valid && o_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      half_q      <= 1'b0;
      o_row_valid <= 1'b0;
    end else begin
      o_row_valid <= take && half_q;
      if (take) half_q <= !half_q;
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !half_q) lo_q <= i_data;
    if (take && half_q) begin
      o_row      <= {i_data, lo_q};
      o_row_last <= i_last;
    end
  end

endmodule

`default_nettype wire

// File: pingpong_bank.sv
// ----------------------------------------------------------
// Two-bank row store for the weight rotator
// One bank is filled through its own write pointer while the
// other is replayed cyclically, read latency of one cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pingpong_bank
  import rot_cfg_pkg::*;
(
  input  logic aclk,
  input  logic aresetn,
  bank_if.bank bif
);

  logic [ROW_WIDTH-1:0] mem [2][BANK_DEPTH];
  logic [ADDR_BITS-1:0] wr_ptr [2];
  logic [ADDR_BITS-1:0] rd_ptr;
  logic                 rd_wrap;

  // Read side wraps once per kernel by channel block
  assign rd_wrap = (rd_ptr == bif.addr_max);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr[0] <= '0;
      wr_ptr[1] <= '0;
    end else if (bif.clr_wr) begin
      wr_ptr[bif.sel_wr] <= '0;
    end else if (bif.wr_en) begin
      wr_ptr[bif.sel_wr] <= wr_ptr[bif.sel_wr] + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_ptr       <= '0;
      bif.rd_valid <= 1'b0;
    end else begin
      bif.rd_valid <= bif.rd_en;
      if (bif.rd_en) rd_ptr <= rd_wrap ? '0 : rd_ptr + 1'b1;
    end
  end

  // Storage and registered read port
  always_ff @(posedge aclk) begin
    if (bif.wr_en) mem[bif.sel_wr][wr_ptr[bif.sel_wr]] <= bif.wr_data;
    if (bif.rd_en) bif.rd_data <= mem[bif.sel_rd][rd_ptr];
  end

endmodule

`default_nettype wire

// File: loop_nest.sv
// ----------------------------------------------------------
// Replay loop counters of the weight rotator
// Kernel, channel, column, block and pass counters step once
// per bank read; flags are registered so they line up with
// the read data one cycle later
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module loop_nest
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      i_start,
  input  hdr_cfg_t  i_cfg,
  input  logic      i_step,
  output logic      o_last,
  output rot_user_t o_user
);

  logic [KW_BITS-1:0]   k_cnt;
  logic [CIN_BITS-1:0]  c_cnt;
  logic [COLS_BITS-1:0] col_cnt;
  logic [BLK_BITS-1:0]  blk_cnt;
  logic [XN_BITS-1:0]   xn_cnt;
  logic                 l_k, l_c, l_col, l_blk, l_xn;
  logic                 w_first_q, cin_last_q, w_last_q;

  assign l_k   = (k_cnt == {i_cfg.kw2, 1'b0});
  assign l_c   = (c_cnt == i_cfg.cin_1);
  assign l_col = (col_cnt == i_cfg.cols_1);
  assign l_blk = (blk_cnt == i_cfg.blocks_1);
  assign l_xn  = (xn_cnt == i_cfg.xn_1);

  always_ff @(posedge aclk) begin
    if (!aresetn || i_start) begin
      k_cnt      <= '0;
      c_cnt      <= '0;
      col_cnt    <= '0;
      blk_cnt    <= '0;
      xn_cnt     <= '0;
      w_first_q  <= 1'b0;
      cin_last_q <= 1'b0;
      w_last_q   <= 1'b0;
      o_last     <= 1'b0;
    end else if (i_step) begin
      // Flags of the row being read now
      w_first_q  <= (k_cnt == '0) && (c_cnt == '0) && (col_cnt == '0);
      cin_last_q <= l_k && l_c;
      w_last_q   <= l_col;
      o_last     <= l_k && l_c && l_col && l_blk && l_xn;

      k_cnt <= l_k ? '0 : k_cnt + 1'b1;
      if (l_k) c_cnt <= l_c ? '0 : c_cnt + 1'b1;
      if (l_k && l_c) col_cnt <= l_col ? '0 : col_cnt + 1'b1;
      if (l_k && l_c && l_col) blk_cnt <= l_blk ? '0 : blk_cnt + 1'b1;
      if (l_k && l_c && l_col && l_blk) xn_cnt <= l_xn ? '0 : xn_cnt + 1'b1;
    end
  end

  assign o_user.is_config   = 1'b0;  // Config beat is marked at the top
  assign o_user.kw2         = i_cfg.kw2;
  assign o_user.is_w_first  = w_first_q;
  assign o_user.is_cin_last = cin_last_q;
  assign o_user.is_w_last   = w_last_q;

endmodule

`default_nettype wire

// File: out_skid.sv
// ----------------------------------------------------------
// Two-entry output FIFO ahead of the master stream
// o_space allows one more bank read, counting the beat that
// is already in flight from the bank
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module out_skid
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 i_valid,
  input  logic [ROW_WIDTH-1:0] i_data,
  input  rot_user_t            i_user,
  input  logic                 i_last,
  output logic                 o_space,
  output logic                 o_valid,
  input  logic                 i_ready,
  output logic [ROW_WIDTH-1:0] o_data,
  output rot_user_t            o_user,
  output logic                 o_last
);

  logic [ROW_WIDTH-1:0] data_q [2];
  rot_user_t            user_q [2];
  logic                 last_q [2];
  logic                 wr_idx, rd_idx;
  logic [1:0]           count;
  logic                 pop;
  logic [2:0]           occ_next;  // Fill level after this cycle

  assign o_valid  = (count != 2'd0);
  assign pop      = o_valid && i_ready;
  assign occ_next = {1'b0, count} + {2'b00, i_valid} - {2'b00, pop};
  assign o_space  = (occ_next < 3'd2);

  assign o_data = data_q[rd_idx];
  assign o_user = user_q[rd_idx];
  assign o_last = last_q[rd_idx];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_idx <= 1'b0;
      rd_idx <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (i_valid) wr_idx <= !wr_idx;
      if (pop) rd_idx <= !rd_idx;
      count <= occ_next[1:0];
    end
  end

  always_ff @(posedge aclk) begin
    if (i_valid) begin
      data_q[wr_idx] <= i_data;
      user_q[wr_idx] <= i_user;
      last_q[wr_idx] <= i_last;
    end
  end

endmodule

`default_nettype wire

// File: rot_ctrl.sv
// ----------------------------------------------------------
// Write and read control of the weight rotator
// Writer takes a header and fills one bank, reader replays
// the other; done flags hand each bank between the two
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rot_ctrl
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
(
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               i_s_valid,
  input  logic [S_WIDTH-1:0] i_s_data,
  input  logic               i_s_last,
  output logic               o_s_ready,
  input  logic               i_pk_ready,   // Packer can take a beat
  input  logic               i_row_valid,  // Packer row on wr_data
  bank_if.ctrl               bif,
  input  logic               i_space,
  input  logic               i_last,       // Final row issued, from loop_nest
  output logic               o_start,
  output hdr_u               o_cfg,
  output logic               o_step,
  output logic               o_cfg_beat,
  output logic               o_pk_en
);

  enum logic [2:0] {W_IDLE, W_GET_HDR, W_WRITE, W_FILL, W_SWITCH} w_state;
  enum logic [1:0] {R_IDLE, R_CONFIG, R_READ, R_SWITCH} r_state;

  logic [1:0] done_write;  // Bank filled, may be replayed
  logic [1:0] done_read;   // Bank replayed, may be refilled
  logic       sel_wr, sel_rd;
  logic       got_last;
  hdr_u       hdr_q [2];
  logic       hdr_acc, cfg_req;

  assign hdr_acc   = (w_state == W_GET_HDR) && i_s_valid;
  assign o_pk_en   = (w_state == W_WRITE) && !got_last;
  assign o_s_ready = (w_state == W_GET_HDR) || i_pk_ready;

  assign bif.wr_en    = (w_state == W_WRITE) && i_row_valid;
  assign bif.clr_wr   = hdr_acc;
  assign bif.sel_wr   = sel_wr;
  assign bif.sel_rd   = sel_rd;
  assign bif.addr_max = o_cfg.cfg.addr_max;
  assign o_cfg        = hdr_q[sel_rd];

  assign o_start = (r_state == R_IDLE) && done_write[sel_rd];
  assign cfg_req = (r_state == R_CONFIG) && i_space;
  assign o_step  = (r_state == R_READ) && i_space && !i_last;
  assign bif.rd_en = o_step;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_state <= W_IDLE;
    end else begin
      case (w_state)
        W_IDLE:    if (done_read[sel_wr]) w_state <= W_GET_HDR;
        W_GET_HDR: if (i_s_valid) w_state <= W_WRITE;
        W_WRITE:   if (bif.wr_en && bif.wr_last) w_state <= W_FILL;
        W_FILL:    w_state <= W_SWITCH;
        default:   w_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_state <= R_IDLE;
    end else begin
      case (r_state)
        R_IDLE:   if (o_start) r_state <= R_CONFIG;
        R_CONFIG: if (cfg_req) r_state <= R_READ;
        R_READ:   if (i_last) r_state <= R_SWITCH;
        default:  r_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_write <= 2'b00;
      done_read  <= 2'b11;  // Both banks free to fill
      sel_wr     <= 1'b0;
      sel_rd     <= 1'b0;
      got_last   <= 1'b0;
      o_cfg_beat <= 1'b0;
    end else begin
      o_cfg_beat <= cfg_req;  // Same latency as a bank read
      if (hdr_acc) begin
        got_last          <= 1'b0;
        done_read[sel_wr] <= 1'b0;
      end else if (o_s_ready && i_s_valid && i_s_last) begin
        got_last <= 1'b1;
      end
      if (w_state == W_FILL) done_write[sel_wr] <= 1'b1;
      if (w_state == W_SWITCH) sel_wr <= !sel_wr;
      if (r_state == R_SWITCH) begin
        done_read[sel_rd]  <= 1'b1;
        done_write[sel_rd] <= 1'b0;
        sel_rd             <= !sel_rd;
      end
    end
  end

  // Header per bank, kept until the bank is refilled
  always_ff @(posedge aclk) begin
    if (hdr_acc) hdr_q[sel_wr].raw <= i_s_data;
  end

endmodule

`default_nettype wire

// File: weight_rotator.sv
// ----------------------------------------------------------
// Weight rotator top level
// Weight packets enter on the slave stream and are replayed
// on the 64-bit master stream with flattened sideband flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module weight_rotator
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 i_s_valid,
  output logic                 o_s_ready,
  input  logic [S_WIDTH-1:0]   i_s_data,
  input  logic                 i_s_last,
  output logic                 o_m_valid,
  input  logic                 i_m_ready,
  output logic [ROW_WIDTH-1:0] o_m_data,
  output logic                 o_m_last,
  output logic                 o_m_is_config,
  output logic [KW2_BITS-1:0]  o_m_kw2,
  output logic                 o_m_is_w_first,
  output logic                 o_m_is_cin_last,
  output logic                 o_m_is_w_last
);

  bank_if bif ();

  logic                 pk_en, pk_ready, row_valid;
  logic                 space, start, step, cfg_beat, ln_last;
  logic                 sk_valid, sk_last;
  logic [ROW_WIDTH-1:0] sk_data;
  hdr_u                 cfg;
  rot_user_t            ln_user, sk_user, m_user;

  rot_ctrl u_ctrl (
    .aclk, .aresetn, .i_s_valid, .i_s_data, .i_s_last, .o_s_ready,
    .i_pk_ready(pk_ready), .i_row_valid(row_valid), .bif(bif.ctrl),
    .i_space(space), .i_last(ln_last), .o_start(start), .o_cfg(cfg),
    .o_step(step), .o_cfg_beat(cfg_beat), .o_pk_en(pk_en)
  );

  row_packer u_packer (
    .aclk, .aresetn, .i_valid(i_s_valid), .o_ready(pk_ready), .i_data(i_s_data),
    .i_last(i_s_last), .i_en(pk_en), .o_row_valid(row_valid),
    .o_row(bif.wr_data), .o_row_last(bif.wr_last)
  );

  pingpong_bank u_bank (.aclk, .aresetn, .bif(bif.bank));

  loop_nest u_loops (
    .aclk, .aresetn, .i_start(start), .i_cfg(cfg.cfg), .i_step(step),
    .o_last(ln_last), .o_user(ln_user)
  );

  // Config beat or bank row into the output FIFO
  assign sk_valid = bif.rd_valid || cfg_beat;
  assign sk_last  = ln_last && !cfg_beat;

  always_comb begin
    sk_data = bif.rd_data;
    sk_user = ln_user;
    if (cfg_beat) begin
      sk_data           = {{(ROW_WIDTH - S_WIDTH){1'b0}}, cfg.raw};
      sk_user           = '0;
      sk_user.is_config = 1'b1;
      sk_user.kw2       = cfg.cfg.kw2;
    end
  end

  out_skid u_skid (
    .aclk, .aresetn, .i_valid(sk_valid), .i_data(sk_data), .i_user(sk_user),
    .i_last(sk_last), .o_space(space), .o_valid(o_m_valid), .i_ready(i_m_ready),
    .o_data(o_m_data), .o_user(m_user), .o_last(o_m_last)
  );

  assign o_m_is_config   = m_user.is_config;
  assign o_m_kw2         = m_user.kw2;
  assign o_m_is_w_first  = m_user.is_w_first;
  assign o_m_is_cin_last = m_user.is_cin_last;
  assign o_m_is_w_last   = m_user.is_w_last;

endmodule

`default_nettype wire

// File: weight_rotator_checker.sv
// ----------------------------------------------------------
// Bound assertions for the weight rotator ports
// Keeps its own header list and loop counters to predict the
// replay order, payload, flags and last beat of each packet
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module weight_rotator_checker
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 i_s_valid,
  input  logic                 i_s_ready,
  input  logic [S_WIDTH-1:0]   i_s_data,
  input  logic                 i_s_last,
  input  logic                 i_m_valid,
  input  logic                 i_m_ready,
  input  logic [ROW_WIDTH-1:0] i_m_data,
  input  logic                 i_m_last,
  input  logic                 i_m_is_config,
  input  logic [KW2_BITS-1:0]  i_m_kw2,
  input  logic                 i_m_is_w_first,
  input  logic                 i_m_is_cin_last,
  input  logic                 i_m_is_w_last,
  output int                   o_err_count
);

  hdr_u                 hdr_mem [8];  // Headers in arrival order
  hdr_u                 cur;
  logic [2:0]           hdr_cnt, out_pkt;
  logic                 in_first;     // Next input beat is a header
  logic                 exp_cfg;      // Next output beat is a config beat
  logic [KW_BITS-1:0]   k;
  logic [CIN_BITS-1:0]  c;
  logic [COLS_BITS-1:0] col;
  logic [BLK_BITS-1:0]  blk;
  logic [XN_BITS-1:0]   xn;
  logic [ADDR_BITS-1:0] row;
  logic                 k_max, c_max, col_max, blk_max, xn_max, m_fire;
  logic [ROW_WIDTH-1:0] exp_data;
  logic [2:0]           exp_flags;
  logic                 exp_last;

  initial o_err_count = 0;

  assign cur     = hdr_mem[out_pkt];
  assign m_fire  = i_m_valid && i_m_ready;
  assign k_max   = (k == {cur.cfg.kw2, 1'b0});  // Kernel width 2*kw2+1
  assign c_max   = (c == cur.cfg.cin_1);
  assign col_max = (col == cur.cfg.cols_1);
  assign blk_max = (blk == cur.cfg.blocks_1);
  assign xn_max  = (xn == cur.cfg.xn_1);

  // Row payload is {packet, row index}
  assign exp_data  = exp_cfg ? {32'b0, cur.raw} : {29'b0, out_pkt, 24'b0, row};
  assign exp_flags = exp_cfg ? 3'b000
                             : {(k == '0) && (c == '0) && (col == '0), k_max && c_max, col_max};
  assign exp_last  = !exp_cfg && k_max && c_max && col_max && blk_max && xn_max;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      hdr_cnt  <= '0;
      out_pkt  <= '0;
      in_first <= 1'b1;
      exp_cfg  <= 1'b1;
      k        <= '0;
      c        <= '0;
      col      <= '0;
      blk      <= '0;
      xn       <= '0;
      row      <= '0;
    end else begin
      if (i_s_valid && i_s_ready) begin
        if (in_first) begin
          hdr_mem[hdr_cnt].raw <= i_s_data;
          hdr_cnt              <= hdr_cnt + 3'd1;
        end
        in_first <= i_s_last;
      end
      if (m_fire && exp_cfg) begin
        exp_cfg <= 1'b0;
      end else if (m_fire) begin
        row <= (row == cur.cfg.addr_max) ? '0 : row + 1'b1;  // Cyclic bank replay
        k   <= k_max ? '0 : k + 1'b1;
        if (k_max) c <= c_max ? '0 : c + 1'b1;
        if (k_max && c_max) col <= col_max ? '0 : col + 1'b1;
        if (k_max && c_max && col_max) blk <= blk_max ? '0 : blk + 1'b1;
        if (k_max && c_max && col_max && blk_max) xn <= xn_max ? '0 : xn + 1'b1;
        if (exp_last) begin
          exp_cfg <= 1'b1;
          out_pkt <= out_pkt + 3'd1;
        end
      end
    end
  end

  a_reset_idle: assert property (@(posedge aclk) $rose(aresetn) |-> !i_s_ready && !i_m_valid)
    else begin
      o_err_count++;
      $error("o_s_ready or o_m_valid high on the first cycle after reset");
    end

  a_hdr_first: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> hdr_cnt > out_pkt)
    else begin
      o_err_count++;
      $error("output beat shows up before its packet header was accepted");
    end

  a_config: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> i_m_is_config == exp_cfg)
    else begin
      o_err_count++;
      $error("FAIL o_m_is_config got %h exp %h", $sampled(i_m_is_config), $sampled(exp_cfg));
    end

  a_kw2: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> i_m_kw2 == cur.cfg.kw2)
    else begin
      o_err_count++;
      $error("FAIL o_m_kw2 got %h exp %h", $sampled(i_m_kw2), $sampled(cur.cfg.kw2));
    end

  a_data: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> i_m_data == exp_data)
    else begin
      o_err_count++;
      $error("FAIL o_m_data got %h exp %h", $sampled(i_m_data), $sampled(exp_data));
    end

  a_last: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> i_m_last == exp_last)
    else begin
      o_err_count++;
      $error("FAIL o_m_last got %h exp %h", $sampled(i_m_last), $sampled(exp_last));
    end

  a_flags: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid |-> {i_m_is_w_first, i_m_is_cin_last, i_m_is_w_last} == exp_flags)
    else begin
      o_err_count++;
      $error("FAIL o_m_is_w_first,o_m_is_cin_last,o_m_is_w_last got %h exp %h",
             $sampled({i_m_is_w_first, i_m_is_cin_last, i_m_is_w_last}), $sampled(exp_flags));
    end

  // Stalled beat stays put until taken
  a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data) && $stable(i_m_last))
    else begin
      o_err_count++;
      $error("o_m_valid dropped or o_m_data changed before the transfer");
    end

  a_overlap: assert property (@(posedge aclk) disable iff (!aresetn)
    m_fire && i_m_last && out_pkt == 3'd0 |-> hdr_cnt >= 3'd2)
    else begin
      o_err_count++;
      $error("second packet header was not taken before the first replay ended");
    end

endmodule

`default_nettype wire

// File: tb_weight_rotator.sv
// ----------------------------------------------------------
// Testbench for the weight rotator
// Sends three weight packets with random geometry and random
// stalls; the bound checker judges the output stream
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_weight_rotator
  import rot_cfg_pkg::*;
  import rot_hdr_pkg::*;
();

  localparam int NUM_PKTS   = 3;
  localparam int WAIT_LIMIT = 4000;   // Cycles per input beat
  localparam int DONE_LIMIT = 20000;

  logic                 aclk;
  logic                 aresetn;
  logic                 i_s_valid;
  logic                 o_s_ready;
  logic [S_WIDTH-1:0]   i_s_data;
  logic                 i_s_last;
  logic                 o_m_valid;
  logic                 i_m_ready;
  logic [ROW_WIDTH-1:0] o_m_data;
  logic                 o_m_last;
  logic                 o_m_is_config;
  logic [KW2_BITS-1:0]  o_m_kw2;
  logic                 o_m_is_w_first;
  logic                 o_m_is_cin_last;
  logic                 o_m_is_w_last;

  logic [31:0] stim_lfsr;
  int          tb_errs = 0;
  int          pkts_done;
  logic        timed_out;  // Stops the stimulus after a stuck wait

  weight_rotator DUT (.*);

  bind weight_rotator weight_rotator_checker u_chk (
    .aclk, .aresetn, .i_s_valid, .i_s_ready(o_s_ready), .i_s_data, .i_s_last,
    .i_m_valid(o_m_valid), .i_m_ready, .i_m_data(o_m_data), .i_m_last(o_m_last),
    .i_m_is_config(o_m_is_config), .i_m_kw2(o_m_kw2), .i_m_is_w_first(o_m_is_w_first),
    .i_m_is_cin_last(o_m_is_cin_last), .i_m_is_w_last(o_m_is_w_last), .o_err_count()
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      r = {r[6:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  task automatic finish_run();
    int chk_errs;
    chk_errs = DUT.u_chk.o_err_count;
    $display("Errors: %0d assertion, %0d testbench", chk_errs, tb_errs);
    if (chk_errs + tb_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    tb_errs++;
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  task automatic send_beat(input logic [S_WIDTH-1:0] data, input logic last, input logic may_gap);
    logic [7:0] g;
    logic       took;
    int         waited;
    if (timed_out) return;
    took   = 1'b0;
    waited = 0;
    g      = rand_bits(2);
    if (may_gap && g[1:0] == 2'd0) begin
      i_s_valid <= 1'b0;  // One idle cycle
      @(posedge aclk);
    end
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    i_s_last  <= last;
    while (!took && waited < WAIT_LIMIT) begin
      @(negedge aclk);
      took = o_s_ready;  // Transfer happens on the next edge
      @(posedge aclk);
      waited++;
    end
    if (!took) report_timeout("input stream never accepted a beat");
  endtask

  task automatic wait_replays();
    int waited;
    waited = 0;
    while (pkts_done < NUM_PKTS && waited < DONE_LIMIT) begin
      @(posedge aclk);
      waited++;
    end
    if (pkts_done < NUM_PKTS) report_timeout("replay of all packets did not finish");
  endtask

  always @(negedge aclk) begin
    if (!aresetn) pkts_done <= 0;
    else if (o_m_valid && i_m_ready && o_m_last) pkts_done <= pkts_done + 1;
  end

  // Output back-pressure, ready about three cycles in four
  initial begin : ready_gen
    logic [31:0] s;
    logic        a;
    s         = 32'hae80;
    i_m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      s = lfsr_step(s);
      a = s[0];
      s = lfsr_step(s);
      i_m_ready <= a | s[0];
    end
  end

  initial begin : stimulus
    hdr_u       hdr;
    int         rows;
    logic [7:0] g;
    stim_lfsr = 32'hae80;
    timed_out = 1'b0;
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    for (int p = 0; p < NUM_PKTS && !timed_out; p++) begin
      g                 = rand_bits(6);
      hdr.raw           = '0;
      hdr.cfg.kw2       = {1'b0, g[0]};
      hdr.cfg.cin_1     = {2'b0, g[2:1]};
      hdr.cfg.cols_1    = {3'b0, g[3]} + 4'd1;  // At least two columns
      hdr.cfg.blocks_1  = {2'b0, g[4]};
      hdr.cfg.xn_1      = {2'b0, g[5]} + 3'd1;
      rows              = (2 * int'(hdr.cfg.kw2) + 1) * (int'(hdr.cfg.cin_1) + 1);
      hdr.cfg.addr_max  = 8'(rows - 1);
      send_beat(hdr.raw, 1'b0, 1'b0);
      for (int r = 0; r < rows && !timed_out; r++) begin
        send_beat(32'(r), 1'b0, 1'b1);            // Low half, row index
        send_beat(32'(p), r == rows - 1, 1'b1);   // High half, packet number
      end
    end
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
    if (!timed_out) wait_replays();
    repeat (8) @(posedge aclk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: filelist.f
rot_cfg_pkg.sv
rot_hdr_pkg.sv
bank_if.sv
row_packer.sv
pingpong_bank.sv
loop_nest.sv
out_skid.sv
rot_ctrl.sv
weight_rotator.sv
weight_rotator_checker.sv
tb_weight_rotator.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_weight_rotator -f filelist.f || exit 1
out=$(./obj_dir/Vtb_weight_rotator +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF "All tests passed!" && exit 0 || exit 1
